// ==== Makefile ====
# Verilator build and run of the controller testbench

TOP := tb_ctrl_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the trace testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// ==== hw/bus_err_tracker.sv ====
// Outstanding data-bus counter, store/load order queue and NMI latch
`timescale 1ns/1ps
`include "ctrl_consts.svh"

module bus_err_tracker (
  input  logic clk,
  input  logic rst_n,
  input  logic obi_req_i,
  input  logic obi_gnt_i,
  input  logic obi_we_i,
  input  logic obi_rvalid_i,
  input  logic obi_err_i,
  input  logic nmi_taken_i,
  output logic nmi_pending_o,
  output logic nmi_is_store_o,
  output logic outstanding_zero_o
);

  localparam logic [`CTRL_CNT_W-1:0] CNT_MAX = `CTRL_MAX_OUTSTANDING;

  logic [`CTRL_CNT_W-1:0] cnt_q;
  // Write bit per outstanding access, oldest in entry 0
  logic [1:0]             we_q;
  logic                   granted;

  assign granted            = obi_req_i && obi_gnt_i;
  assign outstanding_zero_o = (cnt_q == '0);

  //////////////////////////////
  // Outstanding count
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (granted && !obi_rvalid_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (!granted && obi_rvalid_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // A response retires entry 0 and the queue shifts down
  // A grant appends behind whatever is still in flight
  always_ff @(posedge clk) begin
    if (granted && obi_rvalid_i) begin
      if (cnt_q == CNT_MAX) begin
        we_q[0] <= we_q[1];
        we_q[1] <= obi_we_i;
      end else begin
        we_q[0] <= obi_we_i;
      end
    end else if (granted) begin
      we_q[cnt_q[0]] <= obi_we_i;
    end else if (obi_rvalid_i) begin
      we_q[0] <= we_q[1];
    end
  end

  //////////////////////////////
  // NMI latch
  //////////////////////////////

  // The first error wins and later ones are dropped until the NMI is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      nmi_pending_o  <= 1'b0;
      nmi_is_store_o <= 1'b0;
    end else if (obi_rvalid_i && obi_err_i && !nmi_pending_o) begin
      nmi_pending_o  <= 1'b1;
      nmi_is_store_o <= we_q[0];
    end else if (nmi_taken_i) begin
      nmi_pending_o <= 1'b0;
    end
  end

  a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_MAX)
    else $error("bus_err_tracker: outstanding count above the limit");

endmodule

// ==== hw/ctrl_consts.svh ====
// Width and limit macros shared by the controller
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

//////////////////////////////
// Data bus
//////////////////////////////

// Most data-bus transactions the core may have in flight at once
`define CTRL_MAX_OUTSTANDING 2

// Outstanding counter width, wide enough to hold the limit itself
`define CTRL_CNT_W 2

//////////////////////////////
// Writeback and redirect
//////////////////////////////

// Writeback info word describing the retiring instruction
`define CTRL_INFO_W 8

// Encoding width of the program counter source select
`define CTRL_PC_MUX_W 3

`endif

// ==== hw/ctrl_fsm.sv ====
// Controller FSM issuing pc_set, pc_mux, irq_ack, sleep and fence.i start
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_enable_i,
  input  logic                wb_valid_i,
  input  ctrl_pkg::wb_info_u  wb_info_i,
  input  logic                wb_is_sys_i,
  input  logic                irq_i,
  input  logic                nmi_pending_i,
  input  logic                nmi_allowed_i,
  input  logic                interrupt_allowed_i,
  input  logic                fencei_done_i,
  output logic                pc_set_o,
  output ctrl_pkg::pc_mux_e   pc_mux_o,
  output logic                irq_ack_o,
  output logic                sleep_o,
  output logic                nmi_taken_o,
  output logic                fencei_start_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_d;
  ctrl_pkg::pc_mux_e     pc_mux_d;
  logic                  pc_set_d;
  logic                  take_nmi;
  logic                  take_irq;
  logic                  sys_retire;
  logic                  in_functional;

  assign in_functional = (state_q == ctrl_pkg::FUNCTIONAL);
  assign sys_retire    = wb_valid_i && wb_is_sys_i;

  // Traps are only taken from FUNCTIONAL and the NMI goes ahead of the interrupt
  assign take_nmi = in_functional && nmi_pending_i && nmi_allowed_i;
  assign take_irq = in_functional && irq_i && interrupt_allowed_i && !nmi_pending_i;

  // The tracker clears its latch on the edge that raises the NMI redirect
  assign nmi_taken_o = take_nmi;

  //////////////////////////////
  // Next state and redirects
  //////////////////////////////

  always_comb begin
    state_d        = state_q;
    pc_set_d       = 1'b0;
    pc_mux_d       = pc_mux_o;
    fencei_start_o = 1'b0;
    unique case (state_q)
      ctrl_pkg::RESET: begin
        if (fetch_enable_i) begin
          state_d  = ctrl_pkg::BOOT_SET;
          pc_set_d = 1'b1;
          pc_mux_d = ctrl_pkg::PC_BOOT;
        end
      end
      ctrl_pkg::BOOT_SET: begin
        state_d = ctrl_pkg::FUNCTIONAL;
      end
      ctrl_pkg::FUNCTIONAL: begin
        // Priority is NMI, interrupt, then the retiring system instruction
        if (take_nmi) begin
          pc_set_d = 1'b1;
          pc_mux_d = ctrl_pkg::PC_TRAP_NMI;
        end else if (take_irq) begin
          pc_set_d = 1'b1;
          pc_mux_d = ctrl_pkg::PC_TRAP_IRQ;
        end else if (sys_retire && wb_info_i.sys.mret) begin
          pc_set_d = 1'b1;
          pc_mux_d = ctrl_pkg::PC_MRET;
        end else if (sys_retire && wb_info_i.sys.fencei) begin
          state_d        = ctrl_pkg::FENCEI_WAIT;
          fencei_start_o = 1'b1;
        end else if (sys_retire && wb_info_i.sys.wfi) begin
          state_d = ctrl_pkg::SLEEP;
        end
      end
      ctrl_pkg::SLEEP: begin
        // Only wake up here since the trap itself is decided again in FUNCTIONAL
        if (irq_i || nmi_pending_i) begin
          state_d = ctrl_pkg::FUNCTIONAL;
        end
      end
      ctrl_pkg::FENCEI_WAIT: begin
        // Done marks req and ack together, so the redirect lines up with the falling request
        if (fencei_done_i) begin
          state_d  = ctrl_pkg::FUNCTIONAL;
          pc_set_d = 1'b1;
          pc_mux_d = ctrl_pkg::PC_FENCEI;
        end
      end
      default: begin
        state_d = ctrl_pkg::RESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= ctrl_pkg::RESET;
      pc_set_o  <= 1'b0;
      pc_mux_o  <= ctrl_pkg::PC_BOOT;
      irq_ack_o <= 1'b0;
      sleep_o   <= 1'b0;
    end else begin
      state_q   <= state_d;
      pc_set_o  <= pc_set_d;
      pc_mux_o  <= pc_mux_d;
      irq_ack_o <= take_irq;
      sleep_o   <= (state_d == ctrl_pkg::SLEEP);
    end
  end

  // Retirement after an mret redirect belongs to the handler, never a second mret
  a_no_back_to_back_mret: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_set_o && (pc_mux_o == ctrl_pkg::PC_MRET)) |=>
    !(pc_set_o && (pc_mux_o == ctrl_pkg::PC_MRET)))
    else $error("ctrl_fsm: two mret redirects back to back");

  // A bus error can only arrive with a transaction outstanding, which blocks the interrupt
  a_irq_ack_no_nmi: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_o |-> !nmi_pending_i)
    else $error("ctrl_fsm: irq_ack_o while an NMI is pending");

  a_irq_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_o |=> !irq_ack_o)
    else $error("ctrl_fsm: irq_ack_o longer than one cycle");

endmodule

// ==== hw/ctrl_pkg.sv ====
// FSM state enum, pc source enum and writeback info union of the controller
`include "ctrl_consts.svh"

package ctrl_pkg;

  // Controller FSM states
  // RESET waits for fetch enable and BOOT_SET lasts a single cycle
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    FUNCTIONAL  = 3'd2,
    SLEEP       = 3'd3,
    FENCEI_WAIT = 3'd4
  } ctrl_state_e;

  // Program counter sources selected on a redirect
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT     = 3'd0,
    PC_MRET     = 3'd1,
    PC_FENCEI   = 3'd2,
    PC_TRAP_IRQ = 3'd3,
    PC_TRAP_NMI = 3'd4
  } pc_mux_e;

  // Writeback info word with two decodings
  // The memory view applies to loads and stores, the system view when wb_is_sys is high
  // Both views keep first_op and last_op in the same two top bits
  typedef union packed {
    struct packed {
      logic                   first_op;
      logic                   last_op;
      logic [`CTRL_INFO_W-5:0] rsvd;
      logic                   lsu_we;
      logic                   lsu_en;
    } mem;
    struct packed {
      logic                   first_op;
      logic                   last_op;
      logic [`CTRL_INFO_W-6:0] rsvd;
      logic                   mret;
      logic                   fencei;
      logic                   wfi;
    } sys;
  } wb_info_u;

endpackage

// ==== hw/ctrl_top.sv ====
// Controller top level connecting the FSM, bus error tracker, fence.i sequencer and gate
`timescale 1ns/1ps

module ctrl_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               fetch_enable_i,
  input  logic               wb_valid_i,
  input  ctrl_pkg::wb_info_u wb_info_i,
  input  logic               wb_is_sys_i,
  input  logic               obi_req_i,
  input  logic               obi_gnt_i,
  input  logic               obi_we_i,
  input  logic               obi_rvalid_i,
  input  logic               obi_err_i,
  input  logic               irq_i,
  input  logic               fencei_flush_ack_i,
  output logic               pc_set_o,
  output ctrl_pkg::pc_mux_e  pc_mux_o,
  output logic               irq_ack_o,
  output logic               fencei_flush_req_o,
  output logic               nmi_is_store_o,
  output logic               sleep_o
);

  logic nmi_pending;
  logic outstanding_zero;
  logic interrupt_allowed;
  logic nmi_allowed;
  logic fencei_done;
  logic nmi_taken;
  logic fencei_start;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  ctrl_fsm ctrl_fsm_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable_i),
    .wb_valid_i          (wb_valid_i),
    .wb_info_i           (wb_info_i),
    .wb_is_sys_i         (wb_is_sys_i),
    .irq_i               (irq_i),
    .nmi_pending_i       (nmi_pending),
    .nmi_allowed_i       (nmi_allowed),
    .interrupt_allowed_i (interrupt_allowed),
    .fencei_done_i       (fencei_done),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .irq_ack_o           (irq_ack_o),
    .sleep_o             (sleep_o),
    .nmi_taken_o         (nmi_taken),
    .fencei_start_o      (fencei_start)
  );

  // Data bus side
  bus_err_tracker bus_err_tracker_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .obi_req_i          (obi_req_i),
    .obi_gnt_i          (obi_gnt_i),
    .obi_we_i           (obi_we_i),
    .obi_rvalid_i       (obi_rvalid_i),
    .obi_err_i          (obi_err_i),
    .nmi_taken_i        (nmi_taken),
    .nmi_pending_o      (nmi_pending),
    .nmi_is_store_o     (nmi_is_store_o),
    .outstanding_zero_o (outstanding_zero)
  );

  fencei_handshake fencei_handshake_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fencei_start_i     (fencei_start),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .fencei_flush_req_o (fencei_flush_req_o),
    .fencei_done_o      (fencei_done)
  );

  // A pending flush request counts as fence.i in progress
  trap_gate trap_gate_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .wb_valid_i          (wb_valid_i),
    .wb_info_i           (wb_info_i),
    .wb_is_sys_i         (wb_is_sys_i),
    .outstanding_zero_i  (outstanding_zero),
    .fencei_busy_i       (fencei_flush_req_o),
    .interrupt_allowed_o (interrupt_allowed),
    .nmi_allowed_o       (nmi_allowed)
  );

endmodule

// ==== hw/fencei_handshake.sv ====
// Fence.i flush request/acknowledge sequencer
`timescale 1ns/1ps

module fencei_handshake (
  input  logic clk,
  input  logic rst_n,
  input  logic fencei_start_i,
  input  logic fencei_flush_ack_i,
  output logic fencei_flush_req_o,
  output logic fencei_done_o
);

  // Request and acknowledge together close the handshake
  // The FSM registers its redirect on this, so it lands with the falling request
  assign fencei_done_o = fencei_flush_req_o && fencei_flush_ack_i;

  // Request rises the cycle after start and holds until it is acknowledged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fencei_flush_req_o <= 1'b0;
    end else if (fencei_start_i) begin
      fencei_flush_req_o <= 1'b1;
    end else if (fencei_done_o) begin
      fencei_flush_req_o <= 1'b0;
    end
  end

  //////////////////////////////
  // Protocol checks
  //////////////////////////////

  // The flush unit only answers a pending request
  a_ack_only_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    fencei_flush_ack_i |-> fencei_flush_req_o)
    else $error("fencei_handshake: acknowledge without a pending request");

  // The FSM stays in FENCEI_WAIT for the whole handshake
  a_no_start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    fencei_start_i |-> !fencei_flush_req_o)
    else $error("fencei_handshake: start while a request is pending");

endmodule

// ==== hw/trap_gate.sv ====
// Multi-op sequence tracking and the interrupt and NMI allowed decisions
`timescale 1ns/1ps

module trap_gate (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wb_valid_i,
  input  ctrl_pkg::wb_info_u wb_info_i,
  input  logic               wb_is_sys_i,
  input  logic               outstanding_zero_i,
  input  logic               fencei_busy_i,
  output logic               interrupt_allowed_o,
  output logic               nmi_allowed_o
);

  logic seq_open_q;
  logic seq_open_d;
  logic lsu_retire;

  //////////////////////////////
  // Sequence tracking
  //////////////////////////////

  // first_op and last_op sit at the same place in both views
  // A single-op instruction has both set and leaves the sequence closed
  always_comb begin
    seq_open_d = seq_open_q;
    if (wb_valid_i) begin
      if (wb_info_i.mem.last_op) begin
        seq_open_d = 1'b0;
      end else if (wb_info_i.mem.first_op) begin
        seq_open_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_open_q <= 1'b0;
    end else begin
      seq_open_q <= seq_open_d;
    end
  end

  // Memory view only when the retiring instruction is not a system one
  assign lsu_retire = wb_valid_i && !wb_is_sys_i && wb_info_i.mem.lsu_en;

  // The redirect lands after this retirement, so judge the state it leaves behind
  assign nmi_allowed_o = !seq_open_d;

  assign interrupt_allowed_o = !seq_open_d && outstanding_zero_i && !lsu_retire &&
                               !fencei_busy_i;

endmodule

// ==== testbench/ctrl_trace.txt ====
// in:  fetch_en wb_valid wb_info wb_is_sys obi_req obi_gnt obi_we obi_rvalid obi_err irq f_ack
// out: pc_set pc_mux irq_ack fencei_req nmi_is_store sleep, all expected in the same cycle
// boot one cycle after fetch enable
0 0 00 0 0 0 0 0 0 0 0   0 0 0 0 0 0
1 0 00 0 0 0 0 0 0 0 0   0 0 0 0 0 0
1 0 00 0 0 0 0 0 0 0 0   1 0 0 0 0 0
// mret, then fence.i with a late acknowledge
1 1 c4 1 0 0 0 0 0 0 0   0 0 0 0 0 0
1 0 00 0 0 0 0 0 0 0 0   1 1 0 0 0 0
1 1 c2 1 0 0 0 0 0 0 0   0 0 0 0 0 0
1 0 00 0 0 0 0 0 0 0 0   0 0 0 1 0 0
1 0 00 0 0 0 0 0 0 0 0   0 0 0 1 0 0
1 0 00 0 0 0 0 0 0 0 1   0 0 0 1 0 0
1 0 00 0 0 0 0 0 0 0 0   1 2 0 0 0 0
// wfi sleep, woken by irq, interrupt taken
1 1 c1 1 0 0 0 0 0 0 0   0 0 0 0 0 0
1 0 00 0 0 0 0 0 0 0 0   0 0 0 0 0 1
1 0 00 0 0 0 0 0 0 1 0   0 0 0 0 0 1
1 0 00 0 0 0 0 0 0 1 0   0 0 0 0 0 0
1 0 00 0 0 0 0 0 0 0 0   1 3 1 0 0 0
// irq held off by an outstanding load and an open sequence
1 0 00 0 1 1 0 0 0 0 0   0 0 0 0 0 0
1 1 80 0 0 0 0 0 0 1 0   0 0 0 0 0 0
1 0 00 0 0 0 0 1 0 1 0   0 0 0 0 0 0
1 0 00 0 0 0 0 0 0 1 0   0 0 0 0 0 0
1 1 40 0 0 0 0 0 0 1 0   0 0 0 0 0 0
1 0 00 0 0 0 0 0 0 0 0   1 3 1 0 0 0
// store then load, error on both responses
1 0 00 0 1 1 1 0 0 0 0   0 0 0 0 0 0
1 0 00 0 1 1 0 0 0 0 0   0 0 0 0 0 0
1 0 00 0 0 0 0 1 1 0 0   0 0 0 0 0 0
1 0 00 0 0 0 0 1 1 0 0   0 0 0 0 1 0
1 0 00 0 0 0 0 0 0 0 0   1 4 0 0 1 0
1 0 00 0 0 0 0 0 0 0 0   0 0 0 0 1 0
1 0 00 0 0 0 0 0 0 0 0   0 0 0 0 1 0
1 0 00 0 0 0 0 0 0 0 0   0 0 0 0 1 0

// ==== testbench/tb_clkgen.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

  // Reset drops on a falling edge so the first active edge sees a settled rst_n
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== testbench/tb_ctrl_top.sv ====
// Trace reader, stimulus, output checks and watchdog of the controller testbench
`timescale 1ns/1ps

module tb_ctrl_top;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam int MAX_ROWS     = 64;
  localparam int NUM_COLS     = 17;
  // Margin the watchdog grants on top of reset and the trace itself
  localparam int SLACK_CYCLES = 20;

  logic               clk;
  logic               rst_n;
  logic               fetch_enable_i     = 1'b0;
  logic               wb_valid_i         = 1'b0;
  ctrl_pkg::wb_info_u wb_info_i          = '0;
  logic               wb_is_sys_i        = 1'b0;
  logic               obi_req_i          = 1'b0;
  logic               obi_gnt_i          = 1'b0;
  logic               obi_we_i           = 1'b0;
  logic               obi_rvalid_i       = 1'b0;
  logic               obi_err_i          = 1'b0;
  logic               irq_i              = 1'b0;
  logic               fencei_flush_ack_i = 1'b0;
  logic               pc_set_o;
  ctrl_pkg::pc_mux_e  pc_mux_o;
  logic               irq_ack_o;
  logic               fencei_flush_req_o;
  logic               nmi_is_store_o;
  logic               sleep_o;

  // Columns 0..10 are inputs, 11..16 the expected outputs of the same cycle
  logic [7:0]  rows [MAX_ROWS][NUM_COLS];
  int          n_rows       = 0;
  logic        trace_ready  = 1'b0;
  int          drive_idx    = 0;
  int          check_idx    = 0;
  logic [31:0] rnd_state    = 32'h82d8;
  int          n_checks     = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  tb_clkgen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) clkgen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ctrl_top ctrl_top_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .wb_valid_i         (wb_valid_i),
    .wb_info_i          (wb_info_i),
    .wb_is_sys_i        (wb_is_sys_i),
    .obi_req_i          (obi_req_i),
    .obi_gnt_i          (obi_gnt_i),
    .obi_we_i           (obi_we_i),
    .obi_rvalid_i       (obi_rvalid_i),
    .obi_err_i          (obi_err_i),
    .irq_i              (irq_i),
    .fencei_flush_ack_i (fencei_flush_ack_i),
    .pc_set_o           (pc_set_o),
    .pc_mux_o           (pc_mux_o),
    .irq_ack_o          (irq_ack_o),
    .fencei_flush_req_o (fencei_flush_req_o),
    .nmi_is_store_o     (nmi_is_store_o),
    .sleep_o            (sleep_o)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // 32-bit xorshift that feeds only the don't-care bus bits
  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Comment lines scan as zero fields and are skipped
  task automatic load_trace();
    int    fd;
    int    cnt;
    int    line_no;
    int    i;
    int    f [NUM_COLS];
    string line;
    line_no = 0;
    fd = $fopen("testbench/ctrl_trace.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("could not open the trace file testbench/ctrl_trace.txt");
    end else begin
      while (!$feof(fd) && (n_rows < MAX_ROWS)) begin
        line = "";
        void'($fgets(line, fd));
        line_no++;
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                      f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
        if (cnt == NUM_COLS) begin
          for (i = 0; i < NUM_COLS; i++) begin
            rows[n_rows][i] = f[i][7:0];
          end
          n_rows++;
        end else if (cnt > 0) begin
          other_errors++;
          $display("trace line %0d has %0d columns where %0d are needed", line_no, cnt,
                   NUM_COLS);
        end
      end
      $fclose(fd);
    end
    if (n_rows == 0) begin
      other_errors++;
      $display("the trace holds no stimulus rows");
    end
    trace_ready = 1'b1;
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    n_checks++;
    assert (actual === expected)
      else begin
        value_errors++;
        $display("error at %0d ns: %s expected %0b, got %0b", $time, name, expected, actual);
      end
  endtask

  task automatic check_mux(input logic [2:0] expected, input logic [2:0] actual);
    n_checks++;
    assert (actual === expected)
      else begin
        value_errors++;
        $display("error at %0d ns: pc_mux_o expected %0d, got %0d", $time, expected, actual);
      end
  endtask

  // The pc source only means something in a cycle that redirects
  task automatic check_row(input int k);
    check_bit("pc_set_o", rows[k][11][0], pc_set_o);
    if (rows[k][11][0]) begin
      check_mux(rows[k][12][2:0], pc_mux_o);
    end
    check_bit("irq_ack_o", rows[k][13][0], irq_ack_o);
    check_bit("fencei_flush_req_o", rows[k][14][0], fencei_flush_req_o);
    check_bit("nmi_is_store_o", rows[k][15][0], nmi_is_store_o);
    check_bit("sleep_o", rows[k][16][0], sleep_o);
  endtask

  //////////////////////////////
  // Stimulus and checking
  //////////////////////////////

  // One row per rising edge once reset is released
  always @(posedge clk) begin
    logic [31:0] rnd;
    if (rst_n && trace_ready && (drive_idx < n_rows)) begin
      fetch_enable_i     <= rows[drive_idx][0][0];
      wb_valid_i         <= rows[drive_idx][1][0];
      wb_info_i          <= rows[drive_idx][2];
      wb_is_sys_i        <= rows[drive_idx][3][0];
      obi_rvalid_i       <= rows[drive_idx][7][0];
      obi_err_i          <= rows[drive_idx][8][0];
      irq_i              <= rows[drive_idx][9][0];
      fencei_flush_ack_i <= rows[drive_idx][10][0];
      if (rows[drive_idx][4][0]) begin
        obi_req_i <= 1'b1;
        obi_gnt_i <= rows[drive_idx][5][0];
        obi_we_i  <= rows[drive_idx][6][0];
      end else begin
        // Without a request the grant and write bits cannot start a transfer
        rnd = next_random(rnd_state);
        rnd_state <= rnd;
        obi_req_i <= 1'b0;
        obi_gnt_i <= rnd[0];
        obi_we_i  <= rnd[9];
      end
      drive_idx <= drive_idx + 1;
    end
  end

  // Registered outputs are settled by the falling edge
  always @(negedge clk) begin
    if (check_idx < drive_idx) begin
      check_row(check_idx);
      check_idx <= check_idx + 1;
    end
  end

  initial begin
    load_trace();
    wait (check_idx >= n_rows);
    @(posedge clk);
    $display("%0d checks, %0d value errors, %0d other errors", n_checks, value_errors,
             other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from reset, the trace length and a fixed margin
  initial begin
    int limit_cycles;
    wait (trace_ready === 1'b1);
    limit_cycles = RESET_CYCLES + n_rows + SLACK_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before the trace finished", limit_cycles);
    $display("test failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/ctrl_pkg.sv
hw/ctrl_fsm.sv
hw/bus_err_tracker.sv
hw/fencei_handshake.sv
hw/trap_gate.sv
hw/ctrl_top.sv
testbench/tb_clkgen.sv
testbench/tb_ctrl_top.sv
